/* build.f */
+incdir+source
source/fedp_fmt_pkg.sv
source/fedp_stage_pkg.sv
source/fedp_pipe_reg.sv
source/fedp_mul_exp.sv
source/fedp_csa_acc.sv
source/fedp_norm_round.sv
source/fedp_dot.sv
sim/fedp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the dot-product testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module fedp_tb -o fedp_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fedp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* sim/fedp_tb.sv */
// ***************************************************************************
// Testbench for the fused dot-product unit. Streams random and directed
// dot products through the DUT and checks each d_val against a reference
// model once four enabled edges have passed.
// ***************************************************************************

`timescale 1ns/10ps
`include "fedp_settings.svh"

module fedp_tb;

    typedef logic [`FEDP_LANES-1:0][`FEDP_XLEN-1:0] row_t;

    localparam int TERMS     = `FEDP_TERMS;
    localparam int LAT       = `FEDP_MUL_LAT + `FEDP_ACC_LAT + `FEDP_RND_LAT;
    localparam int RESET_CYC = 16;
    localparam int N_FP16    = 200;
    localparam int N_BF16    = 200;
    localparam int N_ZERO    = 23;
    localparam int N_GAP     = 300;
    localparam int N_MIXED   = 104;
    // Each test drains for at most LAT + 2 cycles
    localparam int LIMIT     = RESET_CYC + N_FP16 + N_BF16 + N_ZERO + N_GAP + N_MIXED
                             + 6 * (LAT + 2) + 100;

    logic                     clk;
    logic                     arst_n;
    logic                     enable;
    fedp_fmt_pkg::elem_fmt_e  fmt_s;
    row_t                     a_row;
    row_t                     b_col;
    logic [31:0]              c_val;
    logic [31:0]              d_val;

    logic                     issue;
    logic                     fresh = 1'b0;
    logic [LAT-1:0]           age = '0;
    logic [31:0]              held = '0;
    logic [31:0]              exp_q[$];
    logic [31:0]              lcg_state = 32'h4ced7559;
    int                       checks = 0;
    int                       errors = 0;
    int                       chk_mark;
    int                       err_mark;
    int                       cycles = 0;

    fedp_dot DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (enable),
        .fmt_s  (fmt_s),
        .a_row  (a_row),
        .b_col  (b_col),
        .c_val  (c_val),
        .d_val  (d_val)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = lcg_next();
        return lo + int'(r[31:8] % 24'(hi - lo + 1));
    endfunction

    // Normal element with a biased exponent in [emin, emax]
    function automatic logic [15:0] rand_elem(input fedp_fmt_pkg::elem_fmt_e fmt,
                                              input int emin, input int emax);
        logic [31:0] r;
        int          e;
        r = lcg_next();
        e = rand_range(emin, emax);
        if (fmt == fedp_fmt_pkg::FMT_BF16) begin
            return {r[31], 8'(e), r[22:16]};
        end
        return {r[31], 5'(e), r[25:16]};
    endfunction

    function automatic row_t rand_row(input fedp_fmt_pkg::elem_fmt_e fmt,
                                      input int emin, input int emax);
        row_t row;
        for (int i = 0; i < `FEDP_LANES; i++) begin
            row[i] = {rand_elem(fmt, emin, emax), rand_elem(fmt, emin, emax)};
        end
        return row;
    endfunction

    function automatic logic [31:0] rand_fp32(input int emin, input int emax);
        logic [31:0] r;
        r = lcg_next();
        return {r[31], 8'(rand_range(emin, emax)), r[22:0]};
    endfunction

    // Expected fp32 result, one aligned sum with truncation, then RNE
    function automatic logic [31:0] fedp_model(input fedp_fmt_pkg::elem_fmt_e fmt,
                                               input row_t a, input row_t b,
                                               input logic [31:0] c);
        int          exps [TERMS];
        longint      sigs [TERMS];
        bit          negs [TERMS];
        bit          live [TERMS];
        logic [15:0] ea;
        logic [15:0] eb;
        int          frac;
        int          max_exp;
        int          msb;
        int          sh;
        longint      total;
        longint      mag;
        longint      kept;
        longint      rem;
        logic        neg;
        for (int k = 0; k < TERMS - 1; k++) begin
            ea = a[k / 2][16 * (k % 2) +: 16];
            eb = b[k / 2][16 * (k % 2) +: 16];
            negs[k] = ea[15] ^ eb[15];
            if (fmt == fedp_fmt_pkg::FMT_BF16) begin
                live[k] = (ea[14:7] != 8'd0) && (eb[14:7] != 8'd0);
                exps[k] = int'(ea[14:7]) + int'(eb[14:7]) - 127;
                sigs[k] = longint'({1'b1, ea[6:0]}) * longint'({1'b1, eb[6:0]});
                frac    = 14;
            end else begin
                live[k] = (ea[14:10] != 5'd0) && (eb[14:10] != 5'd0);
                exps[k] = int'(ea[14:10]) + int'(eb[14:10]) - 30 + 127;
                sigs[k] = longint'({1'b1, ea[9:0]}) * longint'({1'b1, eb[9:0]});
                frac    = 20;
            end
            // Exact product in [1,4), leading one moved to bit 23
            if (sigs[k] >= (64'sd1 <<< (frac + 1))) begin
                sigs[k] = sigs[k] <<< (22 - frac);
                exps[k] = exps[k] + 1;
            end else begin
                sigs[k] = sigs[k] <<< (23 - frac);
            end
        end
        negs[TERMS-1] = c[31];
        live[TERMS-1] = (c[30:23] != 8'd0);
        exps[TERMS-1] = int'(c[30:23]);
        sigs[TERMS-1] = longint'({1'b1, c[22:0]});
        max_exp = 0;
        for (int k = 0; k < TERMS; k++) begin
            if (live[k] && exps[k] > max_exp) begin
                max_exp = exps[k];
            end
        end
        total = 0;
        for (int k = 0; k < TERMS; k++) begin
            if (live[k]) begin
                mag   = sigs[k] >>> (max_exp - exps[k]);
                total = negs[k] ? total - mag : total + mag;
            end
        end
        if (total == 0) begin
            return 32'h0;
        end
        neg = (total < 0);
        mag = neg ? -total : total;
        msb = 0;
        for (int i = 0; i < 40; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        if (msb <= 23) begin
            kept = mag <<< (23 - msb);
            return {neg, 8'(max_exp + msb - 23), kept[22:0]};
        end
        sh   = msb - 23;
        kept = mag >>> sh;
        rem  = mag - (kept <<< sh);
        // Above half rounds up, exactly half goes to the even mantissa
        if (rem > (64'sd1 <<< (sh - 1)) || (rem == (64'sd1 <<< (sh - 1)) && kept[0])) begin
            kept = kept + 1;
        end
        if (kept == (64'sd1 <<< 24)) begin
            kept = kept >>> 1;
            sh   = sh + 1;
        end
        return {neg, 8'(max_exp + sh), kept[22:0]};
    endfunction

    task automatic send_expect(input fedp_fmt_pkg::elem_fmt_e fmt, input row_t a,
                               input row_t b, input logic [31:0] c,
                               input logic [31:0] want);
        @(posedge clk);
        enable <= 1'b1;
        issue  <= 1'b1;
        fmt_s  <= fmt;
        a_row  <= a;
        b_col  <= b;
        c_val  <= c;
        exp_q.push_back(want);
    endtask

    task automatic send_op(input fedp_fmt_pkg::elem_fmt_e fmt, input row_t a,
                           input row_t b, input logic [31:0] c);
        send_expect(fmt, a, b, c, fedp_model(fmt, a, b, c));
    endtask

    task automatic send_random(input fedp_fmt_pkg::elem_fmt_e fmt, input int emin,
                               input int emax, input int cmin, input int cmax);
        send_op(fmt, rand_row(fmt, emin, emax), rand_row(fmt, emin, emax),
                rand_fp32(cmin, cmax));
    endtask

    // Enable low with junk on the data inputs, which must not be captured
    task automatic stall_cycle();
        @(posedge clk);
        enable <= 1'b0;
        issue  <= 1'b0;
        a_row  <= rand_row(fedp_fmt_pkg::FMT_FP16, 1, 30);
        c_val  <= lcg_next();
    endtask

    task automatic start_test();
        chk_mark = checks;
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            enable <= 1'b1;
            issue  <= 1'b0;
        end
        $display("Test %s done: %0d checks, %0d errors", name, checks - chk_mark,
                 errors - err_mark);
    endtask

    // Track which enabled edges carry a tracked operation
    always @(posedge clk) begin
        fresh <= enable;
        if (enable) begin
            age <= {age[LAT-2:0], issue};
        end
    end

    always @(negedge clk) begin : compare
        logic [31:0] want;
        if (fresh && age[LAT-1]) begin
            checks++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: a result arrived with no expected value queued", $time);
            end else begin
                want = exp_q.pop_front();
                if (d_val !== want) begin
                    errors++;
                    $display("[FAIL] %0t d_val: got %h, expected %h", $time, d_val, want);
                end
            end
        end else if (!fresh && arst_n) begin
            checks++;
            if (d_val !== held) begin
                errors++;
                $display("[FAIL] %0t d_val: got %h while enable low, expected held %h",
                         $time, d_val, held);
            end
        end
        held = d_val;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        fedp_fmt_pkg::elem_fmt_e fmt;
        logic [31:0]             r;
        clk    = 1'b0;
        arst_n = 1'b0;
        enable = 1'b0;
        issue  = 1'b0;
        fmt_s  = fedp_fmt_pkg::FMT_FP16;
        a_row  = '0;
        b_col  = '0;
        c_val  = '0;
        repeat (RESET_CYC) @(posedge clk);
        arst_n <= 1'b1;

        start_test();
        @(negedge clk);
        checks++;
        if (d_val !== 32'h0) begin
            errors++;
            $display("[FAIL] %0t d_val: got %h, expected %h", $time, d_val, 32'h0);
        end
        finish_test("reset");

        start_test();
        for (int i = 0; i < N_FP16; i++) begin
            send_random(fedp_fmt_pkg::FMT_FP16, 1, 30, 100, 160);
        end
        finish_test("fp16 stream");

        start_test();
        for (int i = 0; i < N_BF16; i++) begin
            send_random(fedp_fmt_pkg::FMT_BF16, 97, 157, 60, 190);
        end
        finish_test("bf16 stream");

        // Zero operands pass c_val through, exact cancellation gives +0
        start_test();
        for (int i = 0; i < N_ZERO - 3; i++) begin
            r   = lcg_next();
            fmt = r[0] ? fedp_fmt_pkg::FMT_BF16 : fedp_fmt_pkg::FMT_FP16;
            r   = rand_fp32(1, 254);
            send_expect(fmt, '0, '0, r, r);
        end
        send_expect(fedp_fmt_pkg::FMT_FP16, {16'h0, 16'h3c00}, {16'h0, 16'hbc00},
                    32'h3f800000, 32'h0);
        send_expect(fedp_fmt_pkg::FMT_BF16, {16'h0, 16'h3f80}, {16'h0, 16'hbf80},
                    32'h3f800000, 32'h0);
        send_expect(fedp_fmt_pkg::FMT_FP16, {16'h0, 16'h4000}, {16'h0, 16'h3e00},
                    32'hc0400000, 32'h0);
        finish_test("zero and cancel");

        start_test();
        for (int i = 0; i < N_GAP; i++) begin
            r   = lcg_next();
            fmt = r[0] ? fedp_fmt_pkg::FMT_BF16 : fedp_fmt_pkg::FMT_FP16;
            if (r[31:30] == 2'b00) begin
                stall_cycle();
            end else if (fmt == fedp_fmt_pkg::FMT_BF16) begin
                send_random(fmt, 97, 157, 100, 160);
            end else begin
                send_random(fmt, 1, 30, 100, 160);
            end
        end
        finish_test("enable gaps");

        // Wide exponent spread, then hand-worked truncation and tie cases
        start_test();
        for (int i = 0; i < N_MIXED - 4; i++) begin
            if (i % 2 == 0) begin
                send_random(fedp_fmt_pkg::FMT_BF16, 90, 164, 30, 220);
            end else begin
                send_random(fedp_fmt_pkg::FMT_FP16, 1, 30, 60, 200);
            end
        end
        send_expect(fedp_fmt_pkg::FMT_BF16, {16'h0, 16'hbf80}, {16'h0, 16'h3380},
                    32'h3f800000, 32'h3f800000);
        send_expect(fedp_fmt_pkg::FMT_BF16, {16'h0, 16'h3f80}, {16'h0, 16'h3f80},
                    32'h3fffffff, 32'h40400000);
        send_expect(fedp_fmt_pkg::FMT_BF16, {16'h0, 16'h3f80}, {16'h0, 16'h3f80},
                    32'h3f800001, 32'h40000000);
        send_expect(fedp_fmt_pkg::FMT_BF16, {16'h0, 16'h3f80}, {16'h0, 16'h3f80},
                    32'h3f800003, 32'h40000002);
        finish_test("mixed signs");

        $display("Checks: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* source/fedp_csa_acc.sv */
// ***************************************************************************
// Second stage: sums the aligned signed significands through a chain of
// 3:2 compressors and one carry-propagate add, then splits the total into
// sign and magnitude.
// ***************************************************************************

`timescale 1ns/10ps
`include "fedp_settings.svh"

module fedp_csa_acc (
    input  fedp_stage_pkg::aligned_t aligned,
    output fedp_stage_pkg::acc_t     acc
);

    // One extra bit holds the sign of the two's complement total
    localparam int W = `FEDP_ACC_W + 1;

    logic [`FEDP_TERMS-1:0][W-1:0] ext;
    logic [W-1:0] sum_v;
    logic [W-1:0] carry_v;
    logic [W-1:0] total;
    logic [W-1:0] magnitude;

    always_comb begin
        for (int i = 0; i < `FEDP_TERMS; i++) begin
            ext[i] = W'($signed(aligned.sigs[i]));
        end
    end

    // Each layer folds one more term into the sum and carry vectors
    always_comb begin
        logic [W-1:0] s_next;
        logic [W-1:0] c_next;
        s_next  = '0;
        c_next  = '0;
        sum_v   = ext[0];
        carry_v = ext[1];
        for (int i = 2; i < `FEDP_TERMS; i++) begin
            s_next  = sum_v ^ carry_v ^ ext[i];
            c_next  = ((sum_v & carry_v) | (sum_v & ext[i]) | (carry_v & ext[i])) << 1;
            sum_v   = s_next;
            carry_v = c_next;
        end
    end

    assign total     = sum_v + carry_v;
    assign magnitude = total[W-1] ? -total : total;

    // Magnitude always fits, the term count bounds the growth
    assign acc = '{
        sign:    total[W-1],
        max_exp: aligned.max_exp,
        sig:     magnitude[W-2:0]
    };

endmodule

/* source/fedp_dot.sv */
// ***************************************************************************
// Fused dot-product unit top level. Multiplies N words of A by N words of
// B element-wise, adds c_val, and returns fp32 on d_val four enabled
// cycles later. Enable low freezes the whole pipeline.
// ***************************************************************************

`timescale 1ns/10ps
`include "fedp_settings.svh"

module fedp_dot (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  enable,
    input  fedp_fmt_pkg::elem_fmt_e               fmt_s,
    input  logic [`FEDP_LANES-1:0][`FEDP_XLEN-1:0] a_row,
    input  logic [`FEDP_LANES-1:0][`FEDP_XLEN-1:0] b_col,
    input  logic [31:0]                           c_val,
    output logic [31:0]                           d_val
);

    fedp_stage_pkg::aligned_t aligned_d;
    fedp_stage_pkg::aligned_t aligned_q;
    fedp_stage_pkg::acc_t     acc_d;
    fedp_stage_pkg::acc_t     acc_q;
    fedp_stage_pkg::fp32_t    round_d;

    // Products, max exponent and alignment
    fedp_mul_exp mul_exp (
        .fmt_s   (fmt_s),
        .a_row   (a_row),
        .b_col   (b_col),
        .c_val   (c_val),
        .aligned (aligned_d)
    );

    fedp_pipe_reg #(
        .WIDTH ($bits(fedp_stage_pkg::aligned_t)),
        .DEPTH (`FEDP_MUL_LAT)
    ) pipe_align (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .data_in  (aligned_d),
        .data_out (aligned_q)
    );

    // Carry-save sum of all aligned terms
    fedp_csa_acc csa_acc (
        .aligned (aligned_q),
        .acc     (acc_d)
    );

    fedp_pipe_reg #(
        .WIDTH ($bits(fedp_stage_pkg::acc_t)),
        .DEPTH (`FEDP_ACC_LAT)
    ) pipe_acc (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .data_in  (acc_d),
        .data_out (acc_q)
    );

    fedp_norm_round norm_round (
        .acc    (acc_q),
        .result (round_d)
    );

    // Output register drives d_val directly
    fedp_pipe_reg #(
        .WIDTH ($bits(fedp_stage_pkg::fp32_t)),
        .DEPTH (`FEDP_RND_LAT)
    ) pipe_round (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .data_in  (round_d),
        .data_out (d_val)
    );

endmodule

/* source/fedp_fmt_pkg.sv */
// ***************************************************************************
// Number formats known to the dot-product unit: the element format select
// and the field layout of fp16, bf16 and fp32.
// ***************************************************************************

package fedp_fmt_pkg;

    // Source element format, driven on fmt_s
    typedef enum logic [2:0] {
        FMT_FP16 = 3'd0,
        FMT_BF16 = 3'd1
    } elem_fmt_e;

    // IEEE half precision
    localparam int FP16_EXP_W = 5;
    localparam int FP16_MAN_W = 10;
    localparam int FP16_BIAS  = 15;

    // Brain float, same exponent range as fp32
    localparam int BF16_EXP_W = 8;
    localparam int BF16_MAN_W = 7;
    localparam int BF16_BIAS  = 127;

    // Accumulator and result format
    localparam int FP32_EXP_W = 8;
    localparam int FP32_MAN_W = 23;
    localparam int FP32_BIAS  = 127;

endpackage

/* source/fedp_mul_exp.sv */
// ***************************************************************************
// First stage of the dot product: decodes the 16-bit elements, forms every
// product, converts c_val, and aligns all terms to the largest exponent.
// Purely combinational, registered by the top level.
// ***************************************************************************

`timescale 1ns/10ps
`include "fedp_settings.svh"

module fedp_mul_exp (
    input  fedp_fmt_pkg::elem_fmt_e               fmt_s,
    input  logic [`FEDP_LANES-1:0][`FEDP_XLEN-1:0] a_row,
    input  logic [`FEDP_LANES-1:0][`FEDP_XLEN-1:0] b_col,
    input  logic [31:0]                           c_val,
    output fedp_stage_pkg::aligned_t              aligned
);

    localparam int PRODS  = 2 * `FEDP_LANES;
    localparam int MAN_W  = fedp_fmt_pkg::FP32_MAN_W;
    localparam int EXP_W  = fedp_fmt_pkg::FP32_EXP_W;
    localparam int PAD_W  = fedp_fmt_pkg::FP16_MAN_W - fedp_fmt_pkg::BF16_MAN_W;

    // Decoded element, significand with hidden bit at bit 10
    typedef struct packed {
        logic              sign;
        logic              zero;
        logic signed [9:0] exp;
        logic [10:0]       sig;
    } elem_t;

    function automatic elem_t decode_elem(input logic [15:0] bits,
                                          input fedp_fmt_pkg::elem_fmt_e fmt);
        elem_t el;
        el.sign = bits[15];
        if (fmt == fedp_fmt_pkg::FMT_BF16) begin
            el.zero = (bits[fedp_fmt_pkg::BF16_MAN_W +: fedp_fmt_pkg::BF16_EXP_W] == '0);
            el.exp  = 10'(bits[fedp_fmt_pkg::BF16_MAN_W +: fedp_fmt_pkg::BF16_EXP_W])
                    - 10'(fedp_fmt_pkg::BF16_BIAS);
            // Widened to the fp16 significand so both share one multiplier
            el.sig  = {1'b1, bits[fedp_fmt_pkg::BF16_MAN_W-1:0], {PAD_W{1'b0}}};
        end else begin
            el.zero = (bits[fedp_fmt_pkg::FP16_MAN_W +: fedp_fmt_pkg::FP16_EXP_W] == '0);
            el.exp  = 10'(bits[fedp_fmt_pkg::FP16_MAN_W +: fedp_fmt_pkg::FP16_EXP_W])
                    - 10'(fedp_fmt_pkg::FP16_BIAS);
            el.sig  = {1'b1, bits[fedp_fmt_pkg::FP16_MAN_W-1:0]};
        end
        return el;
    endfunction

    logic [PRODS-1:0][15:0] a_elem;
    logic [PRODS-1:0][15:0] b_elem;

    // Terms before alignment, leading one at bit 23
    logic [`FEDP_TERMS-1:0]             t_sign;
    logic [`FEDP_TERMS-1:0]             t_zero;
    logic [`FEDP_TERMS-1:0][EXP_W-1:0]  t_exp;
    logic [`FEDP_TERMS-1:0][MAN_W:0]    t_sig;
    logic [EXP_W-1:0]                   max_exp;

    // Low half is the even element, high half the odd one
    for (genvar i = 0; i < `FEDP_LANES; i++) begin : g_unpack
        assign a_elem[2*i]   = a_row[i][15:0];
        assign a_elem[2*i+1] = a_row[i][31:16];
        assign b_elem[2*i]   = b_col[i][15:0];
        assign b_elem[2*i+1] = b_col[i][31:16];
    end

    always_comb begin
        elem_t             ea;
        elem_t             eb;
        logic [21:0]       prod;
        logic signed [9:0] pexp;
        for (int i = 0; i < PRODS; i++) begin
            ea   = decode_elem(a_elem[i], fmt_s);
            eb   = decode_elem(b_elem[i], fmt_s);
            prod = ea.sig * eb.sig;
            pexp = ea.exp + eb.exp + 10'(fedp_fmt_pkg::FP32_BIAS);
            // Product lies in [1,4), renormalise to a single integer bit
            if (prod[21]) begin
                t_sig[i] = {prod, 2'b00};
                pexp     = pexp + 10'sd1;
            end else begin
                t_sig[i] = {prod[20:0], 3'b000};
            end
            t_sign[i] = ea.sign ^ eb.sign;
            t_zero[i] = ea.zero | eb.zero;
            t_exp[i]  = pexp[EXP_W-1:0];
        end
        // Accumulator input is already biased fp32
        t_sign[PRODS] = c_val[31];
        t_zero[PRODS] = (c_val[30 -: EXP_W] == '0);
        t_exp[PRODS]  = c_val[30 -: EXP_W];
        t_sig[PRODS]  = {1'b1, c_val[MAN_W-1:0]};
    end

    // Largest exponent among the non-zero terms
    always_comb begin
        max_exp = '0;
        for (int i = 0; i < `FEDP_TERMS; i++) begin
            if (!t_zero[i] && t_exp[i] > max_exp) begin
                max_exp = t_exp[i];
            end
        end
    end

    always_comb begin
        logic [EXP_W-1:0] shift;
        logic [MAN_W:0]   mag;
        aligned.max_exp = max_exp;
        for (int i = 0; i < `FEDP_TERMS; i++) begin
            shift = max_exp - t_exp[i];
            // Bits shifted past bit 0 are simply dropped
            mag   = t_zero[i] ? '0 : (t_sig[i] >> shift);
            aligned.sigs[i] = t_sign[i] ? -{1'b0, mag} : {1'b0, mag};
        end
    end

endmodule

/* source/fedp_norm_round.sv */
// ***************************************************************************
// Last stage: finds the leading one of the accumulated magnitude, adjusts
// the exponent, and rounds once to nearest even into an fp32 word.
// ***************************************************************************

`timescale 1ns/10ps
`include "fedp_settings.svh"

module fedp_norm_round (
    input  fedp_stage_pkg::acc_t  acc,
    output fedp_stage_pkg::fp32_t result
);

    localparam int W     = `FEDP_ACC_W;
    localparam int MAN_W = fedp_fmt_pkg::FP32_MAN_W;
    localparam int EXP_W = fedp_fmt_pkg::FP32_EXP_W;
    localparam int POS_W = $clog2(W);
    // Bits left below the mantissa once the leading one sits at the top
    localparam int LOW_W = W - MAN_W - 1;
    localparam logic [LOW_W-1:0] STICKY_MASK = LOW_W'((1 << (LOW_W - 2)) - 1);

    logic [POS_W-1:0] lead_pos;
    logic [W-1:0]     norm;
    logic [LOW_W-1:0] low_bits;
    logic             guard;
    logic             round_bit;
    logic             sticky;
    logic             lsb;
    logic             round_up;
    logic [MAN_W+1:0] rounded;
    logic [EXP_W+1:0] exp_adj;

    // Highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < W; i++) begin
            if (acc.sig[i]) begin
                lead_pos = POS_W'(i);
            end
        end
    end

    assign norm      = acc.sig << (W - 1 - int'(lead_pos));
    assign low_bits  = norm[LOW_W-1:0];
    assign guard     = low_bits[LOW_W-1];
    assign round_bit = low_bits[LOW_W-2];
    assign sticky    = |(low_bits & STICKY_MASK);
    assign lsb       = norm[LOW_W];

    // Ties go to the even mantissa
    assign round_up  = guard & (round_bit | sticky | lsb);
    assign rounded   = {1'b0, norm[W-1 -: MAN_W+1]} + (MAN_W+2)'(round_up);

    // Bit 23 of the sum carries max_exp, a carry out of rounding adds one
    assign exp_adj = (EXP_W+2)'(acc.max_exp) + (EXP_W+2)'(lead_pos)
                   - (EXP_W+2)'(MAN_W) + (EXP_W+2)'(rounded[MAN_W+1]);

    always_comb begin
        if (acc.sig == '0) begin
            result = '0;
        end else begin
            result.sign     = acc.sign;
            result.exponent = exp_adj[EXP_W-1:0];
            // A rounding carry leaves all low bits zero, so the field is zero too
            result.mantissa = rounded[MAN_W-1:0];
        end
    end

endmodule

/* source/fedp_pipe_reg.sv */
// ***************************************************************************
// Delay line of DEPTH registers, all advancing together while enable is
// high. Reset clears every stage, so the output reads zero until filled.
// ***************************************************************************

`timescale 1ns/10ps

module fedp_pipe_reg #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             enable,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [DEPTH-1:0][WIDTH-1:0] stages;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stages <= '0;
        end else if (enable) begin
            stages[0] <= data_in;
            // Older entries move one slot down the chain
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

/* source/fedp_settings.svh */
// ***************************************************************************
// Build-time sizes for the dot-product unit: lane count, word width and the
// register depth behind each pipeline stage. Include wherever a module or a
// package needs them.
// ***************************************************************************

`ifndef FEDP_SETTINGS_SVH
`define FEDP_SETTINGS_SVH

// 32-bit words per operand row or column
`define FEDP_LANES 2
`define FEDP_XLEN 32

// Register depth after each stage, four in total
`define FEDP_MUL_LAT 2
`define FEDP_ACC_LAT 1
`define FEDP_RND_LAT 1

// Two products per word plus the accumulator input
`define FEDP_TERMS (2 * `FEDP_LANES + 1)
`define FEDP_ACC_W (24 + $clog2(`FEDP_TERMS))

`endif

/* source/fedp_stage_pkg.sv */
// ***************************************************************************
// Records handed from one pipeline stage to the next. Each one is a packed
// struct so it can pass through a delay line as a flat vector.
// ***************************************************************************

`include "fedp_settings.svh"

package fedp_stage_pkg;

    // Aligned significand: sign plus 24-bit magnitude, leading one at bit 23
    localparam int ALN_SIG_W = 25;

    typedef logic signed [ALN_SIG_W-1:0] aln_sig_t;

    // Multiplier stage output
    typedef struct packed {
        logic [fedp_fmt_pkg::FP32_EXP_W-1:0] max_exp;
        aln_sig_t [`FEDP_TERMS-1:0]          sigs;
    } aligned_t;

    // Accumulated sum in sign and magnitude form
    // Bit 23 of sig carries the weight of max_exp
    typedef struct packed {
        logic                                sign;
        logic [fedp_fmt_pkg::FP32_EXP_W-1:0] max_exp;
        logic [`FEDP_ACC_W-1:0]              sig;
    } acc_t;

    // Final single precision word
    typedef struct packed {
        logic                                sign;
        logic [fedp_fmt_pkg::FP32_EXP_W-1:0] exponent;
        logic [fedp_fmt_pkg::FP32_MAN_W-1:0] mantissa;
    } fp32_t;

endpackage
